// ==== dma_ctrl_settings.svh ====
/*
 * DMA control block settings
 * bus widths, register region codes and in-region offsets
 */
`ifndef DMA_CTRL_SETTINGS_SVH
`define DMA_CTRL_SETTINGS_SVH

`define DMA_PCIE_ADDR_W 64
`define DMA_AXI_ADDR_W 32
`define DMA_LEN_W 16
`define DMA_TAG_W 8
`define DMA_REG_ADDR_W 16
`define DMA_REG_DATA_W 32
`define DMA_CNT_W 32

// region codes, address bits 11:8
`define DMA_REGION_DESC_RD 4'd1
`define DMA_REGION_DESC_WR 4'd2
`define DMA_REGION_CNT 4'd4

`define DMA_OFS_ENABLE 8'h00
`define DMA_OFS_PCIE_LO 8'h00
`define DMA_OFS_PCIE_HI 8'h04
`define DMA_OFS_AXI 8'h08
`define DMA_OFS_LEN 8'h10
`define DMA_OFS_TAG 8'h14
`define DMA_OFS_STATUS 8'h18

`endif

// ==== dma_ctrl_pkg.sv ====
/*
 * DMA control types
 * completion status word, read raw or as valid bit plus tag
 */
`include "dma_ctrl_settings.svh"

package dma_ctrl_pkg;

    typedef union packed {
        logic [`DMA_REG_DATA_W-1:0] raw;
        struct packed {
            logic valid;
            logic [`DMA_REG_DATA_W-`DMA_TAG_W-2:0] rsvd;
            logic [`DMA_TAG_W-1:0] tag;
        } f;
    } status_word_u;

endpackage

// ==== reg_bus_if.sv ====
/*
 * Register access bus
 * single-cycle write and read strobes from the AXI-lite slave to a
 * register block, read data returned combinationally
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

interface reg_bus_if;

    logic wr;
    logic rd;
    // word offset inside the target
    logic [7:0] offset;
    logic [`DMA_REG_DATA_W-1:0] wdata;
    logic [`DMA_REG_DATA_W-1:0] rdata;

    modport master (
        output wr, rd, offset, wdata,
        input  rdata
    );

    modport target (
        input  wr, rd, offset, wdata,
        output rdata
    );

endinterface

// ==== axil_reg_slave.sv ====
/*
 * AXI-lite register slave
 * runs the write and read channels, routes accesses by region onto
 * the descriptor and counter buses, captures read data
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

module axil_reg_slave (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DMA_REG_ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`DMA_REG_DATA_W-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`DMA_REG_ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`DMA_REG_DATA_W-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    reg_bus_if.master                  desc_bus,
    reg_bus_if.master                  cnt_bus
);

    // bit 0 descriptor bus, bit 1 counter bus
    function automatic logic [1:0] decode(input logic [`DMA_REG_ADDR_W-1:0] addr);
        logic [3:0] region;
        logic top_ok;
        logic desc_hit;
        logic cnt_hit;
        region = addr[11:8];
        top_ok = addr[`DMA_REG_ADDR_W-1:12] == '0;
        desc_hit = top_ok && addr[7:6] == 2'b00 &&
                   (region == 4'd0 || region == `DMA_REGION_DESC_RD ||
                    region == `DMA_REGION_DESC_WR);
        cnt_hit = top_ok && region == `DMA_REGION_CNT;
        return {cnt_hit, desc_hit};
    endfunction

    logic [1:0] w_hit;
    logic [1:0] r_hit;
    logic wr_accept;
    logic rd_accept;
    logic [`DMA_REG_DATA_W-1:0] rd_sel;

    assign w_hit = decode(awaddr);
    assign r_hit = decode(araddr);

    assign wr_accept = awvalid && wvalid && !bvalid;
    // a bus carries one offset, so a read to the bus being written waits a cycle
    assign rd_accept = arvalid && !rvalid && !(wr_accept && |(w_hit & r_hit));

    // descriptor block sees the low region bits in offset[7:6]
    assign desc_bus.wr = wr_accept && w_hit[0];
    assign desc_bus.rd = rd_accept && r_hit[0];
    assign desc_bus.offset = desc_bus.wr ? {awaddr[9:8], awaddr[5:2], 2'b00}
                                         : {araddr[9:8], araddr[5:2], 2'b00};
    assign desc_bus.wdata = wdata;

    assign cnt_bus.wr = wr_accept && w_hit[1];
    assign cnt_bus.rd = rd_accept && r_hit[1];
    assign cnt_bus.offset = cnt_bus.wr ? {awaddr[7:2], 2'b00} : {araddr[7:2], 2'b00};
    assign cnt_bus.wdata = wdata;

    // unmapped reads return zero
    always_comb begin
        rd_sel = '0;
        if (r_hit[0]) begin
            rd_sel = desc_bus.rdata;
        end else if (r_hit[1]) begin
            rd_sel = cnt_bus.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            awready <= wr_accept;
            wready <= wr_accept;
            bvalid <= wr_accept || (bvalid && !bready);
            arready <= rd_accept;
            rvalid <= rd_accept || (rvalid && !rready);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_sel;
        end
    end

    assign bresp = 2'b00;
    assign rresp = 2'b00;

endmodule

// ==== dma_desc_regs.sv ====
/*
 * DMA descriptor registers
 * enable bit, read and write descriptors with valid/ready issue,
 * completion status read-back with acknowledge, interrupt request
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

module dma_desc_regs (
    input  logic                        clk,
    input  logic                        rst,
    reg_bus_if.target                   bus,
    output logic [`DMA_PCIE_ADDR_W-1:0] rd_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]  rd_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]       rd_desc_len,
    output logic [`DMA_TAG_W-1:0]       rd_desc_tag,
    output logic                        rd_desc_valid,
    input  logic                        rd_desc_ready,
    output logic [`DMA_PCIE_ADDR_W-1:0] wr_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]  wr_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]       wr_desc_len,
    output logic [`DMA_TAG_W-1:0]       wr_desc_tag,
    output logic                        wr_desc_valid,
    input  logic                        wr_desc_ready,
    input  logic [`DMA_TAG_W-1:0]       rd_status_tag,
    input  logic                        rd_status_valid,
    output logic                        rd_status_ready,
    input  logic [`DMA_TAG_W-1:0]       wr_status_tag,
    input  logic                        wr_status_valid,
    output logic                        wr_status_ready,
    output logic                        dma_enable,
    output logic                        irq
);

    // index 0 read direction, index 1 write direction
    logic [`DMA_PCIE_ADDR_W-1:0] pcie_addr [2];
    logic [`DMA_AXI_ADDR_W-1:0] axi_addr [2];
    logic [`DMA_LEN_W-1:0] len [2];
    logic [`DMA_TAG_W-1:0] tag [2];
    logic [`DMA_TAG_W-1:0] status_tag [2];
    logic [1:0] desc_valid;
    logic [1:0] desc_ready;
    logic [1:0] status_valid;
    logic [1:0] status_ready;
    logic [1:0] dir_hit;
    logic [1:0] field_wr;
    logic [1:0] tag_wr;
    logic ctrl_hit;
    logic [7:0] reg_ofs;
    dma_ctrl_pkg::status_word_u status_word [2];

    assign reg_ofs = {2'b00, bus.offset[5:0]};
    assign ctrl_hit = bus.offset[7:6] == 2'b00;
    assign dir_hit[0] = {2'b00, bus.offset[7:6]} == `DMA_REGION_DESC_RD;
    assign dir_hit[1] = {2'b00, bus.offset[7:6]} == `DMA_REGION_DESC_WR;

    // descriptor is frozen while it waits for ready
    assign field_wr = {2{bus.wr}} & dir_hit & ~desc_valid;
    assign tag_wr = field_wr & {2{reg_ofs == `DMA_OFS_TAG}};

    assign desc_ready = {wr_desc_ready, rd_desc_ready};
    assign status_valid = {wr_status_valid, rd_status_valid};
    assign status_tag[0] = rd_status_tag;
    assign status_tag[1] = wr_status_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable <= 1'b0;
            desc_valid <= '0;
            status_ready <= '0;
        end else begin
            if (bus.wr && ctrl_hit && reg_ofs == `DMA_OFS_ENABLE) begin
                dma_enable <= bus.wdata[0];
            end
            for (int d = 0; d < 2; d++) begin
                desc_valid[d] <= tag_wr[d] || (desc_valid[d] && !desc_ready[d]);
                // ack only what was pending when read
                status_ready[d] <= bus.rd && dir_hit[d] && reg_ofs == `DMA_OFS_STATUS &&
                                   status_valid[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int d = 0; d < 2; d++) begin
            if (field_wr[d]) begin
                case (reg_ofs)
                    `DMA_OFS_PCIE_LO: pcie_addr[d][`DMA_REG_DATA_W-1:0] <= bus.wdata;
                    `DMA_OFS_PCIE_HI: begin
                        pcie_addr[d][`DMA_PCIE_ADDR_W-1:`DMA_REG_DATA_W] <= bus.wdata;
                    end
                    `DMA_OFS_AXI: axi_addr[d] <= bus.wdata[`DMA_AXI_ADDR_W-1:0];
                    `DMA_OFS_LEN: len[d] <= bus.wdata[`DMA_LEN_W-1:0];
                    `DMA_OFS_TAG: tag[d] <= bus.wdata[`DMA_TAG_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        for (int d = 0; d < 2; d++) begin
            status_word[d].f.valid = status_valid[d];
            status_word[d].f.rsvd = '0;
            status_word[d].f.tag = status_tag[d];
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (ctrl_hit && reg_ofs == `DMA_OFS_ENABLE) begin
            bus.rdata = {{(`DMA_REG_DATA_W-1){1'b0}}, dma_enable};
        end
        for (int d = 0; d < 2; d++) begin
            if (dir_hit[d] && reg_ofs == `DMA_OFS_STATUS) begin
                bus.rdata = status_word[d].raw;
            end
        end
    end

    assign rd_desc_pcie_addr = pcie_addr[0];
    assign rd_desc_axi_addr = axi_addr[0];
    assign rd_desc_len = len[0];
    assign rd_desc_tag = tag[0];
    assign rd_desc_valid = desc_valid[0];
    assign wr_desc_pcie_addr = pcie_addr[1];
    assign wr_desc_axi_addr = axi_addr[1];
    assign wr_desc_len = len[1];
    assign wr_desc_tag = tag[1];
    assign wr_desc_valid = desc_valid[1];
    assign rd_status_ready = status_ready[0];
    assign wr_status_ready = status_ready[1];

    // pending completion on either side
    assign irq = |status_valid;

endmodule

// ==== tlp_counters.sv ====
/*
 * TLP packet counters
 * counts packet ends on the RQ, RC, CQ and CC streams
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

module tlp_counters (
    input  logic       clk,
    input  logic       rst,
    reg_bus_if.target  bus,
    // index rq=0, rc=1, cq=2, cc=3
    input  logic [3:0] pkt_valid,
    input  logic [3:0] pkt_ready,
    input  logic [3:0] pkt_last
);

    logic [`DMA_CNT_W-1:0] count [4];
    logic [3:0] pkt_end;

    // last beat accepted
    assign pkt_end = pkt_valid & pkt_ready & pkt_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 4; k++) begin
                count[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (pkt_end[k]) begin
                    count[k] <= count[k] + 1'b1;
                end
            end
        end
    end

    // counters at 0x00..0x0c, anything above reads zero
    always_comb begin
        bus.rdata = '0;
        if (bus.offset[7:4] == 4'h0) begin
            bus.rdata = count[bus.offset[3:2]];
        end
    end

endmodule

// ==== dma_ctrl_top.sv ====
/*
 * DMA control register block
 * AXI-lite slave with descriptor, status and packet counter registers
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

module dma_ctrl_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DMA_REG_ADDR_W-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`DMA_REG_DATA_W-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`DMA_REG_ADDR_W-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`DMA_REG_DATA_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`DMA_PCIE_ADDR_W-1:0] rd_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]  rd_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]       rd_desc_len,
    output logic [`DMA_TAG_W-1:0]       rd_desc_tag,
    output logic                        rd_desc_valid,
    input  logic                        rd_desc_ready,
    output logic [`DMA_PCIE_ADDR_W-1:0] wr_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]  wr_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]       wr_desc_len,
    output logic [`DMA_TAG_W-1:0]       wr_desc_tag,
    output logic                        wr_desc_valid,
    input  logic                        wr_desc_ready,
    input  logic [`DMA_TAG_W-1:0]       rd_status_tag,
    input  logic                        rd_status_valid,
    output logic                        rd_status_ready,
    input  logic [`DMA_TAG_W-1:0]       wr_status_tag,
    input  logic                        wr_status_valid,
    output logic                        wr_status_ready,
    output logic                        dma_enable,
    output logic                        irq,
    input  logic [3:0]                  pkt_valid,
    input  logic [3:0]                  pkt_ready,
    input  logic [3:0]                  pkt_last
);

    reg_bus_if desc_bus ();
    reg_bus_if cnt_bus ();

    axil_reg_slave u_slave (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .desc_bus(desc_bus.master),
        .cnt_bus(cnt_bus.master)
    );

    dma_desc_regs u_desc (
        .clk(clk), .rst(rst),
        .bus(desc_bus.target),
        .rd_desc_pcie_addr(rd_desc_pcie_addr), .rd_desc_axi_addr(rd_desc_axi_addr),
        .rd_desc_len(rd_desc_len), .rd_desc_tag(rd_desc_tag),
        .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
        .wr_desc_pcie_addr(wr_desc_pcie_addr), .wr_desc_axi_addr(wr_desc_axi_addr),
        .wr_desc_len(wr_desc_len), .wr_desc_tag(wr_desc_tag),
        .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready),
        .rd_status_tag(rd_status_tag), .rd_status_valid(rd_status_valid),
        .rd_status_ready(rd_status_ready),
        .wr_status_tag(wr_status_tag), .wr_status_valid(wr_status_valid),
        .wr_status_ready(wr_status_ready),
        .dma_enable(dma_enable), .irq(irq)
    );

    tlp_counters u_cnt (
        .clk(clk), .rst(rst),
        .bus(cnt_bus.target),
        .pkt_valid(pkt_valid), .pkt_ready(pkt_ready), .pkt_last(pkt_last)
    );

endmodule

// ==== dma_ctrl_chk.sv ====
/*
 * AXI-lite handshake checks
 * bound into the register slave
 */
`timescale 1ns/1ps

module dma_ctrl_chk (
    input logic clk,
    input logic rst,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    int fail_count = 0;

    // a response stays up until it is taken
    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

    // one joint single-cycle pulse per accepted write
    aw_w_together: assert property (@(posedge clk) disable iff (rst)
        (awready || wready) |-> (awready && wready && !$past(awready || wready)))
    else begin
        $error("awready and wready not pulsed together for a single cycle");
        fail_count++;
    end

endmodule

bind axil_reg_slave dma_ctrl_chk chk0 (
    .clk(clk),
    .rst(rst),
    .awready(awready),
    .wready(wready),
    .bvalid(bvalid),
    .bready(bready),
    .rvalid(rvalid),
    .rready(rready)
);

// ==== tb_dma_ctrl_monitor.sv ====
/*
 * DMA control monitor
 * watches the DUT outputs, compares them with the expected values it is
 * handed, counts status acknowledge pulses and keeps the test tally
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

module tb_dma_ctrl_monitor (
    input logic                        clk,
    input logic                        awready,
    input logic [1:0]                  bresp,
    input logic                        arready,
    input logic [`DMA_REG_DATA_W-1:0]  rdata,
    input logic [1:0]                  rresp,
    input logic [`DMA_PCIE_ADDR_W-1:0] rd_desc_pcie_addr,
    input logic [`DMA_AXI_ADDR_W-1:0]  rd_desc_axi_addr,
    input logic [`DMA_LEN_W-1:0]       rd_desc_len,
    input logic [`DMA_TAG_W-1:0]       rd_desc_tag,
    input logic                        rd_desc_valid,
    input logic [`DMA_PCIE_ADDR_W-1:0] wr_desc_pcie_addr,
    input logic [`DMA_AXI_ADDR_W-1:0]  wr_desc_axi_addr,
    input logic [`DMA_LEN_W-1:0]       wr_desc_len,
    input logic [`DMA_TAG_W-1:0]       wr_desc_tag,
    input logic                        wr_desc_valid,
    input logic                        rd_status_ready,
    input logic                        wr_status_ready,
    input logic                        dma_enable,
    input logic                        irq
);

    int test_count = 0;
    int pass_count = 0;
    int error_count = 0;
    int test_errors = 0;
    int ack_count [2] = '{0, 0};
    int ack_base [2] = '{0, 0};

    // status ready is a one-cycle pulse, seen once between edges
    always @(negedge clk) begin
        if (rd_status_ready) ack_count[0]++;
        if (wr_status_ready) ack_count[1]++;
    end

    task automatic compare(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        test_errors++;
    endtask

    // called where rvalid is first seen, so arready is still up
    task automatic check_read(input logic [31:0] exp, input logic is_status);
        dma_ctrl_pkg::status_word_u got_w;
        dma_ctrl_pkg::status_word_u exp_w;
        compare("arready", arready, 1'b1);
        compare("rresp", rresp, 2'b00);
        compare("rdata", rdata, exp);
        if (is_status) begin
            got_w.raw = rdata;
            exp_w.raw = exp;
            compare("status pending", got_w.f.valid, exp_w.f.valid);
            compare("status tag", got_w.f.tag, exp_w.f.tag);
        end
    endtask

    task automatic check_bresp();
        compare("bresp", bresp, 2'b00);
    endtask

    task automatic check_desc(input logic dir, input logic [63:0] pcie,
                              input logic [31:0] axi, input logic [15:0] len,
                              input logic [7:0] tag);
        if (dir) begin
            compare("wr_desc_valid", wr_desc_valid, 1'b1);
            compare("wr_desc_pcie_addr", wr_desc_pcie_addr, pcie);
            compare("wr_desc_axi_addr", wr_desc_axi_addr, axi);
            compare("wr_desc_len", wr_desc_len, len);
            compare("wr_desc_tag", wr_desc_tag, tag);
        end else begin
            compare("rd_desc_valid", rd_desc_valid, 1'b1);
            compare("rd_desc_pcie_addr", rd_desc_pcie_addr, pcie);
            compare("rd_desc_axi_addr", rd_desc_axi_addr, axi);
            compare("rd_desc_len", rd_desc_len, len);
            compare("rd_desc_tag", rd_desc_tag, tag);
        end
    endtask

    task automatic check_desc_idle(input logic dir);
        if (dir) begin
            compare("wr_desc_valid", wr_desc_valid, 1'b0);
        end else begin
            compare("rd_desc_valid", rd_desc_valid, 1'b0);
        end
    endtask

    task automatic check_irq(input logic exp);
        compare("irq", irq, exp);
    endtask

    task automatic check_awready(input logic exp);
        compare("awready", awready, exp);
    endtask

    task automatic check_enable(input logic exp);
        compare("dma_enable", dma_enable, exp);
    endtask

    task automatic mark_acks();
        ack_base[0] = ack_count[0];
        ack_base[1] = ack_count[1];
    endtask

    // bit 0 read status, bit 1 write status
    task automatic check_acks(input logic [1:0] exp);
        compare("rd_status_ready pulses", ack_count[0] - ack_base[0], exp[0]);
        compare("wr_status_ready pulses", ack_count[1] - ack_base[1], exp[1]);
    endtask

    task automatic end_test(input int line_no, input string op);
        test_count++;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d (%s, line %0d): ok", test_count, op, line_no);
        end else begin
            $display("test %0d (%s, line %0d): %0d errors", test_count, op, line_no,
                     test_errors);
        end
        error_count += test_errors;
        test_errors = 0;
    endtask

    task automatic report_counts();
        error_count += test_errors;
        test_errors = 0;
        $display("tests %0d, passed %0d, failed %0d, errors %0d", test_count, pass_count,
                 test_count - pass_count, error_count);
    endtask

endmodule

// ==== tb_dma_ctrl.sv ====
/*
 * DMA control testbench
 * reads operations from the vector file, drives the AXI-lite, descriptor,
 * status and packet ports, and hands expected values to the monitor
 */
`timescale 1ns/1ps
`include "dma_ctrl_settings.svh"

module tb_dma_ctrl;

    localparam int TIMEOUT = 40;

    logic clk;
    logic rst;
    logic [`DMA_REG_ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [`DMA_REG_DATA_W-1:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [`DMA_REG_ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [`DMA_REG_DATA_W-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [`DMA_PCIE_ADDR_W-1:0] rd_desc_pcie_addr;
    logic [`DMA_AXI_ADDR_W-1:0] rd_desc_axi_addr;
    logic [`DMA_LEN_W-1:0] rd_desc_len;
    logic [`DMA_TAG_W-1:0] rd_desc_tag;
    logic rd_desc_valid;
    logic rd_desc_ready;
    logic [`DMA_PCIE_ADDR_W-1:0] wr_desc_pcie_addr;
    logic [`DMA_AXI_ADDR_W-1:0] wr_desc_axi_addr;
    logic [`DMA_LEN_W-1:0] wr_desc_len;
    logic [`DMA_TAG_W-1:0] wr_desc_tag;
    logic wr_desc_valid;
    logic wr_desc_ready;
    logic [`DMA_TAG_W-1:0] rd_status_tag;
    logic rd_status_valid;
    logic rd_status_ready;
    logic [`DMA_TAG_W-1:0] wr_status_tag;
    logic wr_status_valid;
    logic wr_status_ready;
    logic dma_enable;
    logic irq;
    logic [3:0] pkt_valid;
    logic [3:0] pkt_ready;
    logic [3:0] pkt_last;

    int fd;
    int nf;
    int line_no;
    string line;
    string op;
    logic [63:0] f1;
    logic [63:0] f2;
    logic [63:0] f3;
    logic [63:0] f4;
    logic [63:0] f5;
    bit timed_out;

    dma_ctrl_top dut0 (.*);

    tb_dma_ctrl_monitor mon0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic probe(input string name);
        if (name == "awready") return awready;
        if (name == "bvalid") return bvalid;
        if (name == "rvalid") return rvalid;
        if (name == "rd_desc_valid") return rd_desc_valid;
        return wr_desc_valid;
    endfunction

    // sample on falling edges until the signal is seen high
    task automatic wait_for(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!probe(name) && n < TIMEOUT);
        if (!probe(name)) begin
            mon0.note_failure({"timeout waiting for ", name});
            timed_out = 1'b1;
        end
    endtask

    task automatic take_response();
        int stall;
        stall = $urandom % 4;
        wait_for("bvalid");
        if (!timed_out) begin
            mon0.check_bresp();
        end
        repeat (stall) @(posedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        wait_for("awready");
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        take_response();
    endtask

    task automatic axil_read(input logic [15:0] addr, input logic [31:0] exp,
                             input logic [1:0] acks);
        int stall;
        logic is_status;
        stall = $urandom % 4;
        is_status = (addr[11:8] == `DMA_REGION_DESC_RD || addr[11:8] == `DMA_REGION_DESC_WR)
                    && addr[7:0] == `DMA_OFS_STATUS;
        mon0.mark_acks();
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        wait_for("rvalid");
        if (!timed_out) begin
            mon0.check_read(exp, is_status);
            if (addr == '0) begin
                mon0.check_enable(exp[0]);
            end
        end
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        mon0.check_acks(acks);
    endtask

    // second write is presented while the first response is held back
    task automatic stalled_write(input logic [15:0] addr, input logic [31:0] data,
                                 input int hold, input logic [31:0] data2,
                                 input logic [31:0] mid);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        wait_for("awready");
        if (timed_out) return;
        @(posedge clk);
        wdata <= data2;
        repeat (hold) begin
            @(negedge clk);
            mon0.check_awready(1'b0);
        end
        axil_read(addr, mid, 2'b00);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        wait_for("awready");
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        take_response();
    endtask

    task automatic check_descriptor(input logic dir, input logic [63:0] pcie,
                                    input logic [31:0] axi, input logic [15:0] len,
                                    input logic [7:0] tag);
        int hold;
        hold = 1 + $urandom % 3;
        wait_for(dir ? "wr_desc_valid" : "rd_desc_valid");
        if (timed_out) return;
        // fields must stay put while ready is low
        repeat (hold) begin
            mon0.check_desc(dir, pcie, axi, len, tag);
            @(negedge clk);
        end
        @(posedge clk);
        if (dir) begin
            wr_desc_ready <= 1'b1;
        end else begin
            rd_desc_ready <= 1'b1;
        end
        @(posedge clk);
        rd_desc_ready <= 1'b0;
        wr_desc_ready <= 1'b0;
        @(negedge clk);
        mon0.check_desc_idle(dir);
    endtask

    task automatic drive_status(input logic rv, input logic [7:0] rt, input logic wv,
                                input logic [7:0] wt, input logic irq_exp);
        @(posedge clk);
        rd_status_valid <= rv;
        rd_status_tag <= rt;
        wr_status_valid <= wv;
        wr_status_tag <= wt;
        @(negedge clk);
        mon0.check_irq(irq_exp);
    endtask

    // holds the beat for n rising edges
    task automatic drive_packets(input int k, input logic v, input logic r, input logic l,
                                 input int n);
        if (n == 0) return;
        @(posedge clk);
        pkt_valid[k] <= v;
        pkt_ready[k] <= r;
        pkt_last[k] <= l;
        repeat (n) @(posedge clk);
        pkt_valid <= '0;
        pkt_ready <= '0;
        pkt_last <= '0;
    endtask

    task automatic run_op();
        case (op.getc(0))
            "W": begin
                if (nf > 3) begin
                    stalled_write(f1[15:0], f2[31:0], int'(f3), f4[31:0], f5[31:0]);
                end else begin
                    axil_write(f1[15:0], f2[31:0]);
                end
            end
            "R": axil_read(f1[15:0], f2[31:0], f3[1:0]);
            "A": check_descriptor(f1[0], f2, f3[31:0], f4[15:0], f5[7:0]);
            "S": drive_status(f1[0], f2[7:0], f3[0], f4[7:0], f5[0]);
            "P": drive_packets(int'(f1[1:0]), f2[0], f3[0], f4[0], int'(f5));
            default: mon0.note_failure({"unknown operation ", op});
        endcase
    endtask

    initial begin
        void'($urandom(32'h330a_abff));
        timed_out = 1'b0;
        line_no = 0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status_tag = '0;
        rd_status_valid = 1'b0;
        wr_status_tag = '0;
        wr_status_valid = 1'b0;
        pkt_valid = '0;
        pkt_ready = '0;
        pkt_last = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("dma_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            mon0.note_failure("could not open dma_ctrl_vectors.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) == 0) break;
                line_no++;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                nf = $sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5);
                run_op();
                mon0.end_test(line_no, op);
            end
            $fclose(fd);
        end

        mon0.report_counts();
        if (mon0.error_count == 0 && dut0.u_slave.chk0.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dma_ctrl_vectors.txt ====
# W addr data [hold data2 mid] | R addr data acks | A dir pcie axi len tag
# S rd_v rd_tag wr_v wr_tag irq | P stream valid ready last beats (all hex)
R 0000 00000000 0
W 0000 00000001
R 0000 00000001 0
W 0100 89abcdef
W 0104 01234567
W 0108 40001000
W 0110 00000200
W 0114 0000005a
A 0 0123456789abcdef 40001000 0200 5a
W 0200 00002000
W 0204 fedc0000
W 0208 00008000
W 0210 00000040
W 0214 000000c3
A 1 fedc000000002000 00008000 0040 c3
S 1 3c 0 00 1
R 0118 8000003c 1
R 0218 00000000 0
S 0 00 0 00 0
R 0118 00000000 0
S 0 00 1 a5 1
R 0218 800000a5 2
S 1 11 1 22 1
S 0 00 0 00 0
P 0 1 1 1 3
P 0 1 1 0 2
P 0 1 0 1 2
P 1 0 1 1 2
P 2 1 1 1 5
P 3 1 1 1 1
R 0400 00000003 0
R 0404 00000000 0
R 0408 00000005 0
R 040c 00000001 0
W 0000 00000000 4 00000001 00000000
R 0000 00000001 0

// ==== src.f ====
+incdir+.
dma_ctrl_pkg.sv
reg_bus_if.sv
axil_reg_slave.sv
dma_desc_regs.sv
tlp_counters.sv
dma_ctrl_top.sv
dma_ctrl_chk.sv
tb_dma_ctrl_monitor.sv
tb_dma_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DMA control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_ctrl -f src.f -o sim_dma_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dma_ctrl +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
